// File: Makefile
TOP := tb_async_fifo

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the Verilator build directory"

test:
	verilator --binary --timing -Wno-fatal --top-module $(TOP) -f async_fifo.f
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Test OK"

clean:
	rm -rf obj_dir

// File: async_fifo.f
+incdir+logic
logic/fifo_pkg.sv
logic/fifo_ram_if.sv
logic/fifo_dual_port_ram.sv
logic/fifo_wr_ctrl.sv
logic/fifo_rd_ctrl.sv
logic/async_fifo.sv
verification/tb_clk_gen.sv
verification/tb_async_fifo.sv

// File: logic/async_fifo.sv
`timescale 1ns/10ps

module async_fifo (
  input  logic                 wr_clk,
  input  logic                 rd_clk,
  input  logic                 wr_rst_n,
  input  logic                 wr_en,
  input  fifo_pkg::fifo_data_t wr_data,
  input  logic                 rd_en,
  output fifo_pkg::fifo_data_t rd_data,
  output logic                 full,
  output logic                 afull,
  output logic                 empty,
  output logic                 aempty
);

  import fifo_pkg::*;

  fifo_ptr_t wr_ptr_gray;
  fifo_ptr_t rd_ptr_gray;

  fifo_ram_if ram_if ();

  // data goes straight to and from the ram.
  assign ram_if.wr_data = wr_data;
  assign rd_data        = ram_if.rd_data;

  fifo_wr_ctrl u_wr_ctrl (
    .wr_clk      (wr_clk),
    .wr_rst_n    (wr_rst_n),
    .wr_req      (wr_en),
    .ram         (ram_if.wr),
    .rd_ptr_gray (rd_ptr_gray),
    .wr_ptr_gray (wr_ptr_gray),
    .full        (full),
    .afull       (afull)
  );

  fifo_rd_ctrl u_rd_ctrl (
    .rd_clk      (rd_clk),
    .wr_rst_n    (wr_rst_n),
    .rd_req      (rd_en),
    .ram         (ram_if.rd),
    .wr_ptr_gray (wr_ptr_gray),
    .rd_ptr_gray (rd_ptr_gray),
    .empty       (empty),
    .aempty      (aempty)
  );

  fifo_dual_port_ram u_ram (
    .wr_clk   (wr_clk),
    .rd_clk   (rd_clk),
    .wr_rst_n (wr_rst_n),
    .ram      (ram_if.ram)
  );

endmodule

// File: logic/fifo_dual_port_ram.sv
`timescale 1ns/10ps
`include "fifo_macros.svh"

module fifo_dual_port_ram (
  input logic     wr_clk,
  input logic     rd_clk,
  input logic     wr_rst_n,
  fifo_ram_if.ram ram
);

  import fifo_pkg::*;

  fifo_data_t mem [`FIFO_DEPTH];

  // write port, wr_clk domain.
  always_ff @(posedge wr_clk) begin
    if (ram.wr_en) begin
      mem[ram.wr_addr] <= ram.wr_data;
    end
  end

  // registered read port. holds its value between accepted reads.
  always_ff @(posedge rd_clk or negedge wr_rst_n) begin
    if (!wr_rst_n) begin
      ram.rd_data <= '0;
    end else if (ram.rd_en) begin
      ram.rd_data <= mem[ram.rd_addr];
    end
  end

endmodule

// File: logic/fifo_macros.svh
`ifndef FIFO_MACROS_SVH
`define FIFO_MACROS_SVH

// word width in bits.
`define FIFO_DATA_WIDTH 8

// number of entries, a power of two.
`define FIFO_DEPTH 16

// ram address width, log2 of the depth.
`define FIFO_ADDR_WIDTH 4

// afull is set when the write-side level reaches this.
`define FIFO_AFULL 12

// aempty is set when the read-side level drops to this or below.
`define FIFO_AEMPTY 2

`endif

// File: logic/fifo_pkg.sv
`include "fifo_macros.svh"

package fifo_pkg;

  // one data word.
  typedef logic [`FIFO_DATA_WIDTH-1:0] fifo_data_t;

  // ram address, one entry per value.
  typedef logic [`FIFO_ADDR_WIDTH-1:0] fifo_addr_t;

  // pointer with one extra wrap bit, used in binary and gray form.
  typedef logic [`FIFO_ADDR_WIDTH:0] fifo_ptr_t;

  // occupancy, 0 up to the full depth.
  typedef logic [`FIFO_ADDR_WIDTH:0] fifo_level_t;

endpackage

// File: logic/fifo_ram_if.sv
`timescale 1ns/10ps

interface fifo_ram_if;

  import fifo_pkg::*;

  logic       wr_en;
  fifo_addr_t wr_addr;
  fifo_data_t wr_data;
  logic       rd_en;
  fifo_addr_t rd_addr;
  fifo_data_t rd_data;

  // write data is fed in at the top, not by the controller.
  modport wr (
    output wr_en,
    output wr_addr
  );

  modport rd (
    output rd_en,
    output rd_addr
  );

  modport ram (
    input  wr_en,
    input  wr_addr,
    input  wr_data,
    input  rd_en,
    input  rd_addr,
    output rd_data
  );

endinterface

// File: logic/fifo_rd_ctrl.sv
`timescale 1ns/10ps
`include "fifo_macros.svh"

module fifo_rd_ctrl (
  input  logic                rd_clk,
  input  logic                wr_rst_n,
  input  logic                rd_req,
  fifo_ram_if.rd              ram,
  input  fifo_pkg::fifo_ptr_t wr_ptr_gray,
  output fifo_pkg::fifo_ptr_t rd_ptr_gray,
  output logic                empty,
  output logic                aempty
);

  import fifo_pkg::*;

  fifo_ptr_t   rd_ptr;
  fifo_ptr_t   rd_ptr_nxt;
  fifo_ptr_t   rd_gray_nxt;
  fifo_ptr_t   wr_gray_sync1;
  fifo_ptr_t   wr_gray_sync2;
  fifo_ptr_t   wr_ptr_bin;
  fifo_level_t rd_level;
  logic        empty_nxt;

  assign ram.rd_en   = rd_req & ~empty; // reads while empty are dropped.
  assign ram.rd_addr = rd_ptr[`FIFO_ADDR_WIDTH-1:0];

  always_comb begin
    rd_ptr_nxt = rd_ptr;
    if (ram.rd_en) begin
      rd_ptr_nxt = rd_ptr + 1'b1;
    end
  end

  assign rd_gray_nxt = (rd_ptr_nxt >> 1) ^ rd_ptr_nxt;

  always_ff @(posedge rd_clk or negedge wr_rst_n) begin
    if (!wr_rst_n) begin
      rd_ptr      <= '0;
      rd_ptr_gray <= '0;
    end else begin
      rd_ptr      <= rd_ptr_nxt;
      rd_ptr_gray <= rd_gray_nxt;
    end
  end

  // write pointer into the read domain.
  always_ff @(posedge rd_clk or negedge wr_rst_n) begin
    if (!wr_rst_n) begin
      wr_gray_sync1 <= '0;
      wr_gray_sync2 <= '0;
    end else begin
      wr_gray_sync1 <= wr_ptr_gray;
      wr_gray_sync2 <= wr_gray_sync1;
    end
  end

  always_comb begin
    for (int i = 0; i < $bits(fifo_ptr_t); i++) begin
      wr_ptr_bin[i] = ^(wr_gray_sync2 >> i);
    end
  end

  assign rd_level = wr_ptr_bin - rd_ptr_nxt;

  // empty when both pointers match exactly with the wrap bit included.
  assign empty_nxt = (rd_gray_nxt == wr_gray_sync2);

  always_ff @(posedge rd_clk or negedge wr_rst_n) begin
    if (!wr_rst_n) begin
      empty  <= 1'b1;
      aempty <= 1'b1;
    end else begin
      empty  <= empty_nxt;
      aempty <= (rd_level <= `FIFO_AEMPTY);
    end
  end

endmodule

// File: logic/fifo_wr_ctrl.sv
`timescale 1ns/10ps
`include "fifo_macros.svh"

module fifo_wr_ctrl (
  input  logic                wr_clk,
  input  logic                wr_rst_n,
  input  logic                wr_req,
  fifo_ram_if.wr              ram,
  input  fifo_pkg::fifo_ptr_t rd_ptr_gray,
  output fifo_pkg::fifo_ptr_t wr_ptr_gray,
  output logic                full,
  output logic                afull
);

  import fifo_pkg::*;

  fifo_ptr_t   wr_ptr;
  fifo_ptr_t   wr_ptr_nxt;
  fifo_ptr_t   wr_gray_nxt;
  fifo_ptr_t   rd_gray_sync1;
  fifo_ptr_t   rd_gray_sync2;
  fifo_ptr_t   rd_ptr_bin;
  fifo_level_t wr_level;
  logic        full_nxt;

  assign ram.wr_en   = wr_req & ~full; // writes while full are dropped.
  assign ram.wr_addr = wr_ptr[`FIFO_ADDR_WIDTH-1:0];

  always_comb begin
    wr_ptr_nxt = wr_ptr;
    if (ram.wr_en) begin
      wr_ptr_nxt = wr_ptr + 1'b1;
    end
  end

  assign wr_gray_nxt = (wr_ptr_nxt >> 1) ^ wr_ptr_nxt;

  always_ff @(posedge wr_clk or negedge wr_rst_n) begin
    if (!wr_rst_n) begin
      wr_ptr      <= '0;
      wr_ptr_gray <= '0;
    end else begin
      wr_ptr      <= wr_ptr_nxt;
      wr_ptr_gray <= wr_gray_nxt; // registered, so only one bit toggles per step.
    end
  end

  // two-flop synchronizer for the read pointer.
  always_ff @(posedge wr_clk or negedge wr_rst_n) begin
    if (!wr_rst_n) begin
      rd_gray_sync1 <= '0;
      rd_gray_sync2 <= '0;
    end else begin
      rd_gray_sync1 <= rd_ptr_gray;
      rd_gray_sync2 <= rd_gray_sync1;
    end
  end

  // gray back to binary.
  always_comb begin
    for (int i = 0; i < $bits(fifo_ptr_t); i++) begin
      rd_ptr_bin[i] = ^(rd_gray_sync2 >> i);
    end
  end

  assign wr_level = wr_ptr_nxt - rd_ptr_bin;

  // full when the writer is one lap ahead and the top two gray bits differ.
  assign full_nxt = (wr_gray_nxt == {~rd_gray_sync2[`FIFO_ADDR_WIDTH:`FIFO_ADDR_WIDTH-1],
                                     rd_gray_sync2[`FIFO_ADDR_WIDTH-2:0]});

  always_ff @(posedge wr_clk or negedge wr_rst_n) begin
    if (!wr_rst_n) begin
      full  <= 1'b0;
      afull <= 1'b0;
    end else begin
      full  <= full_nxt;
      afull <= (wr_level >= `FIFO_AFULL);
    end
  end

endmodule

// File: verification/async_fifo_cases.txt
# columns: operation letter, count, data value in hex.
# W writes count words up from value, R reads count words, S waits count wr_clk cycles
# and checks the flags, X interleaves for count cycles with value as write bias of 256.
S 4 00
W 1 5a
S 4 00
R 1 00
S 4 00
R 4 00
S 4 00
W 16 00
S 6 00
W 4 a0
S 6 00
R 20 00
S 6 00
W 5 10
S 5 00
R 3 00
S 5 00
W 11 40
S 5 00
R 2 00
S 5 00
R 12 00
S 5 00
W 12 80
R 12 00
S 5 00
X 300 c0
S 6 00
X 300 40
S 6 00
X 400 80
S 6 00
R 20 00
S 6 00
W 16 e0
S 6 00
R 17 00
S 6 00

// File: verification/tb_async_fifo.sv
`timescale 1ns/10ps
`include "fifo_macros.svh"

module tb_async_fifo;

  import fifo_pkg::*;

  localparam string cases_file = "verification/async_fifo_cases.txt";
  localparam int    wr_period  = 14;
  localparam int    rd_period  = 10;

  logic       wr_clk;
  logic       rd_clk;
  logic       wr_rst_n;
  logic       wr_en;
  fifo_data_t wr_data;
  logic       rd_en;
  fifo_data_t rd_data;
  logic       full;
  logic       afull;
  logic       empty;
  logic       aempty;

  fifo_data_t  model [$]; // accepted words not yet read.
  fifo_data_t  expected_rd; // what rd_data holds after the last accepted read.
  logic [31:0] wr_lcg;
  logic [31:0] rd_lcg;
  longint      time_limit;

  byte         step_op [$];
  int          step_count [$];
  fifo_data_t  step_value [$];

  tb_clk_gen #(.period(wr_period)) u_wr_clk_gen (.clk(wr_clk));
  tb_clk_gen #(.period(rd_period)) u_rd_clk_gen (.clk(rd_clk));

  async_fifo u_dut (
    .wr_clk   (wr_clk),
    .rd_clk   (rd_clk),
    .wr_rst_n (wr_rst_n),
    .wr_en    (wr_en),
    .wr_data  (wr_data),
    .rd_en    (rd_en),
    .rd_data  (rd_data),
    .full     (full),
    .afull    (afull),
    .empty    (empty),
    .aempty   (aempty)
  );

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("Test FAILED");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic check_data(input string name, input fifo_data_t got, input fifo_data_t exp);
    if (got !== exp) begin
      abort_run($sformatf("FAIL %s: got 0x%h, expected 0x%h", name, got, exp));
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      abort_run($sformatf("FAIL %s: got 0x%h, expected 0x%h", name, got, exp));
    end
  endtask

  function automatic logic [31:0] lcg_next(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
  endfunction

  task automatic accept_write(input fifo_data_t word);
    if (model.size() == `FIFO_DEPTH) begin
      abort_run("a write was accepted while the FIFO already held all its words");
    end else begin
      model.push_back(word);
    end
  endtask

  task automatic write_words(input int count, input fifo_data_t first, input bit use_lcg,
                             input fifo_data_t bias);
    logic       req;
    fifo_data_t word;
    for (int i = 0; i < count; i++) begin
      @(negedge wr_clk);
      if (use_lcg) begin
        wr_lcg = lcg_next(wr_lcg);
        req    = (wr_lcg[31:24] < bias);
        word   = wr_lcg[23:16];
      end else begin
        req  = 1'b1;
        word = first + fifo_data_t'(i);
      end
      wr_en   = req;
      wr_data = word;
      if (req && !full) begin // full holds until the next rising edge.
        accept_write(word);
      end
    end
    @(negedge wr_clk);
    wr_en = 1'b0;
  endtask

  task automatic read_words(input int count, input bit use_lcg, input fifo_data_t bias);
    logic req;
    for (int i = 0; i < count; i++) begin
      @(negedge rd_clk);
      check_data("rd_data", rd_data, expected_rd);
      if (use_lcg) begin
        rd_lcg = lcg_next(rd_lcg);
        req    = (rd_lcg[27:20] >= bias);
      end else begin
        req = 1'b1;
      end
      rd_en = req;
      if (req && !empty) begin
        if (model.size() == 0) begin
          abort_run("a read was accepted while no word was left to read");
        end else begin
          expected_rd = model.pop_front();
        end
      end
    end
    @(negedge rd_clk);
    check_data("rd_data", rd_data, expected_rd);
    rd_en = 1'b0;
  endtask

  // with both sides idle the flags are exact after a few edges.
  task automatic settle_and_check(input int cycles);
    int size;
    repeat (cycles) @(posedge wr_clk);
    size = model.size();
    @(negedge wr_clk);
    check_flag("full", full, size == `FIFO_DEPTH);
    check_flag("afull", afull, size >= `FIFO_AFULL);
    @(negedge rd_clk);
    check_flag("empty", empty, size == 0);
    check_flag("aempty", aempty, size <= `FIFO_AEMPTY);
  endtask

  task automatic load_cases();
    int         fd;
    string      token;
    string      rest;
    int         count;
    fifo_data_t value;
    fd = $fopen(cases_file, "r");
    if (fd == 0) begin
      abort_run({"could not open the cases file ", cases_file});
    end
    while ($fscanf(fd, "%s", token) == 1) begin
      if (token.getc(0) == "#") begin
        void'($fgets(rest, fd));
      end else if ($fscanf(fd, "%d %h", count, value) == 2) begin
        step_op.push_back(token.getc(0));
        step_count.push_back(count);
        step_value.push_back(value);
      end else begin
        abort_run({"the cases file has a broken line after ", token});
      end
    end
    $fclose(fd);
  endtask

  initial begin
    longint total;
    wr_rst_n    = 1'b0;
    wr_en       = 1'b0;
    wr_data     = '0;
    rd_en       = 1'b0;
    expected_rd = '0;
    wr_lcg      = 32'd68;
    rd_lcg      = 32'd68;
    time_limit  = 0;
    total       = 0;

    load_cases();
    foreach (step_count[i]) begin
      total += step_count[i];
    end
    time_limit = total * wr_period * 4 + 2000;

    // two cycles of the slower clock.
    repeat (2) @(negedge wr_clk);
    wr_rst_n = 1'b1;

    @(negedge rd_clk);
    check_flag("empty", empty, 1'b1);
    check_flag("aempty", aempty, 1'b1);
    check_flag("full", full, 1'b0);
    check_flag("afull", afull, 1'b0);
    check_data("rd_data", rd_data, '0);

    foreach (step_op[i]) begin
      case (step_op[i])
        "W": write_words(step_count[i], step_value[i], 1'b0, '0);
        "R": read_words(step_count[i], 1'b0, '0);
        "S": settle_and_check(step_count[i]);
        "X": begin
          fork
            write_words(step_count[i], '0, 1'b1, step_value[i]);
            read_words(step_count[i], 1'b1, step_value[i]);
          join
        end
        default: abort_run($sformatf("unknown operation in step %0d of the cases file", i));
      endcase
    end

    $display("Test OK");
    $finish;
  end

  // watchdog that starts once the steps are loaded.
  initial begin
    wait (time_limit > 0);
    #(time_limit);
    abort_run($sformatf("the run timed out after %0d ns", time_limit));
  end

endmodule

// File: verification/tb_clk_gen.sv
`timescale 1ns/10ps

module tb_clk_gen #(
  parameter int period = 10 // ns.
) (
  output logic clk
);

  // free running, starts low.
  initial begin
    clk = 1'b0;
    forever begin
      #(period / 2) clk = ~clk;
    end
  end

endmodule
